/* compile.f */
design/slcd_pkg.sv
design/pb_debounce.sv
design/slcd_msg_seq.sv
design/slcd_cmd_encoder.sv
design/slcd_spi_tx.sv
design/slcd_top.sv
dv/slcd_clk_gen.sv
dv/slcd_tb.sv

/* dv/slcd_tb.sv */
//********************
// testbench for the serial LCD top level
// checks the SPI byte stream, framing, glitch rejection and restart
//********************

`timescale 1ns/10ps

module slcd_tb;

	localparam int debounce_ticks = 8;
	localparam int msg_len        = 11;
	localparam logic [8*16-1:0] msg_bits = {"hello world", 40'h0};
	localparam int stream_len      = 13 + msg_len;	// escape bytes plus characters
	localparam int seq_cycles      = stream_len * 19 + 14 * 4;
	localparam int hold_cycles     = 4 * debounce_ticks;
	localparam int watchdog_cycles = 2 * (3 * seq_cycles + 4 * hold_cycles + 100);

	logic lcdclk;
	logic rst;
	logic btn;
	logic ss;
	logic mosi;
	logic sclk;
	logic done;

	logic [7:0]  rx_q[$];	// bytes seen on the link since the last compare
	string       test_name;
	int          errors_value = 0;
	int          errors_frame = 0;
	int          errors_other = 0;
	int          streams_checked = 0;
	int unsigned seed_val;

	slcd_clk_gen #(.period_ns(100), .reset_cycles(3)) slcd_clk_gen_inst (
		.lcdclk(lcdclk), .rst(rst)
	);

	slcd_top #(.msg_text(msg_bits), .msg_len(msg_len), .debounce_ticks(debounce_ticks))
	slcd_top_inst (
		.lcdclk(lcdclk), .rst(rst), .btn(btn), .ss(ss), .mosi(mosi), .sclk(sclk), .done(done)
	);

	// byte n of a full sequence: enable, home, clear, then the message
	function automatic logic [7:0] expected_byte(int n);
		string esc_tail;
		esc_tail = " [3e [0;0H [j";	// ESC sits at 0, 4 and 10
		if (n == 0 || n == 4 || n == 10)
			return 8'h1b;
		else if (n < 13)
			return esc_tail[n];
		else
			return msg_bits[8*16-1 - 8*(n-13) -: 8];
	endfunction

	task automatic finish_run();
		$display("errors: value %0d, framing %0d, other %0d",
			errors_value, errors_frame, errors_other);
		if (errors_value + errors_frame + errors_other == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic check_level(string sig, logic exp_val, logic act_val);
		assert (act_val === exp_val) else begin
			errors_value++;
			$display("Fail %s: %s expected %b actual %b", test_name, sig, exp_val, act_val);
		end
	endtask

	task automatic compare_stream();
		int n;
		int i;
		n = (rx_q.size() < stream_len) ? rx_q.size() : stream_len;
		assert (rx_q.size() == stream_len) else begin
			errors_value++;
			$display("Fail %s: byte count expected %0d actual %0d",
				test_name, stream_len, rx_q.size());
		end
		for (i = 0; i < n; i++) begin
			assert (rx_q[i] == expected_byte(i)) else begin
				errors_value++;
				$display("Fail %s: byte %0d expected 0x%02h actual 0x%02h",
					test_name, i, expected_byte(i), rx_q[i]);
			end
		end
		rx_q.delete();
		streams_checked++;
	endtask

	task automatic wait_stream(int n);
		int cycles;
		cycles = 0;
		while (streams_checked < n && cycles < 2 * seq_cycles) begin
			@(negedge lcdclk);
			cycles++;
		end
		assert (streams_checked >= n) else begin
			errors_other++;
			$display("done did not rise within %0d cycles in %s", 2 * seq_cycles, test_name);
		end
	endtask

	task automatic wait_bytes(int n);
		int cycles;
		cycles = 0;
		while (rx_q.size() < n && cycles < seq_cycles) begin
			@(negedge lcdclk);
			cycles++;
		end
		assert (rx_q.size() >= n) else begin
			errors_other++;
			$display("fewer than %0d bytes arrived in %s", n, test_name);
		end
	endtask

	task automatic pulse_button(int cycles);
		btn = 1'b1;
		repeat (cycles) @(negedge lcdclk);
		btn = 1'b0;
	endtask

	// SPI monitor, sampled mid-cycle where ss, sclk and mosi are settled
	logic       prev_ss   = 1'b1;
	logic       prev_sclk = 1'b0;
	logic       prev_mosi = 1'b0;
	logic [7:0] shift_bits = '0;
	int         bit_cnt = 0;

	always @(negedge lcdclk) begin
		if (!rst) begin
			assert (!(ss && sclk)) else begin
				errors_frame++;
				$display("sclk is high outside a slave-select frame at %0t", $time);
			end
			if (prev_ss && !ss)
				bit_cnt = 0;	// frame opens
			if (!ss && sclk && !prev_sclk) begin
				assert (mosi == prev_mosi) else begin
					errors_frame++;
					$display("Fail framing: mosi at sclk rise expected %b actual %b",
						prev_mosi, mosi);
				end
				shift_bits = {shift_bits[6:0], mosi};
				bit_cnt++;
			end
			if (!prev_ss && ss) begin
				assert (bit_cnt == 8) else begin
					errors_frame++;
					$display("Fail framing: sclk rises per frame expected 8 actual %0d", bit_cnt);
				end
				rx_q.push_back(shift_bits);
			end
		end
		prev_ss   = ss;
		prev_sclk = sclk;
		prev_mosi = mosi;
	end

	// compare on each rising edge of done
	logic done_q = 1'b0;

	always @(negedge lcdclk) begin
		if (!rst && done && !done_q)
			compare_stream();
		done_q = done;
	end

	initial begin : stimulus
		int glitch_len;
		btn = 1'b0;
		test_name = "reset_state";
		seed_val = $urandom(32'h453c_1cc9);
		wait (rst === 1'b0);
		@(negedge lcdclk);
		check_level("ss", 1'b1, ss);
		check_level("sclk", 1'b0, sclk);
		check_level("mosi", 1'b0, mosi);
		check_level("done", 1'b0, done);

		test_name = "byte_stream";
		wait_stream(1);

		test_name = "restart";
		pulse_button(hold_cycles);
		check_level("done", 1'b0, done);	// debounced release still pending here
		wait_bytes(6);
		pulse_button(hold_cycles);	// press again in mid-sequence
		check_level("ss", 1'b1, ss);
		check_level("done", 1'b0, done);
		rx_q.delete();	// bytes of the aborted sequence
		wait_stream(2);

		test_name = "glitch";
		pulse_button(hold_cycles);
		wait_bytes(10);
		glitch_len = 1 + $urandom % (debounce_ticks - 1);
		pulse_button(glitch_len);
		wait_stream(3);
		glitch_len = 1 + $urandom % (debounce_ticks - 1);
		pulse_button(glitch_len);
		repeat (3 * debounce_ticks) @(negedge lcdclk);
		check_level("done", 1'b1, done);

		finish_run();
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge lcdclk);
		errors_other++;
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		finish_run();
	end

endmodule

/* dv/slcd_clk_gen.sv */
//********************
// testbench clock and reset source
// reset is released on a falling edge
//********************

`timescale 1ns/10ps

module slcd_clk_gen #(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 3
) (
	output logic lcdclk,
	output logic rst
);

	initial begin
		lcdclk = 1'b0;
		forever #(period_ns / 2) lcdclk = ~lcdclk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge lcdclk);
		@(negedge lcdclk);
		rst = 1'b0;
	end

endmodule

/* design/slcd_top.sv */
//********************
// serial LCD test top level
// button debounce, message sequencer, encoder, SPI link
//********************

`timescale 1ns/10ps

module slcd_top #(
	// first character in the top byte, unused bytes at the bottom
	parameter logic [8*slcd_pkg::msg_max-1:0] msg_text = {"hello world", 40'h0},
	parameter int msg_len        = 11,
	parameter int debounce_ticks = 8
) (
	input  logic lcdclk,
	input  logic rst,
	input  logic btn,
	output logic ss,
	output logic mosi,
	output logic sclk,
	output logic done
);

	logic                btn_stable;
	logic                init;
	logic                req;
	logic                ack;
	slcd_pkg::lcd_cmd_t  cmd;
	logic                load;
	slcd_pkg::lcd_byte_t tx_byte;
	logic                byte_done;

	pb_debounce #(.debounce_ticks(debounce_ticks)) pb_debounce_inst (
		.lcdclk(lcdclk), .rst(rst), .btn(btn), .btn_stable(btn_stable)
	);

	slcd_msg_seq #(.msg_text(msg_text), .msg_len(msg_len)) slcd_msg_seq_inst (
		.lcdclk(lcdclk), .rst(rst), .btn_stable(btn_stable), .init(init),
		.req(req), .cmd(cmd), .ack(ack), .done(done)
	);

	slcd_cmd_encoder slcd_cmd_encoder_inst (
		.lcdclk(lcdclk), .rst(rst), .init(init), .req(req), .cmd(cmd), .ack(ack),
		.load(load), .tx_byte(tx_byte), .byte_done(byte_done)
	);

	slcd_spi_tx slcd_spi_tx_inst (
		.lcdclk(lcdclk), .rst(rst), .load(load), .tx_byte(tx_byte),
		.byte_done(byte_done), .ss(ss), .mosi(mosi), .sclk(sclk)
	);

endmodule

/* design/slcd_spi_tx.sv */
//********************
// SPI mode 0 transmitter, MSB first
// one slave-select frame per load strobe
//********************

`timescale 1ns/10ps

module slcd_spi_tx (
	input  logic                lcdclk,
	input  logic                rst,
	input  logic                load,
	input  slcd_pkg::lcd_byte_t tx_byte,
	output logic                byte_done,
	output logic                ss,
	output logic                mosi,
	output logic                sclk
);

	slcd_pkg::spi_state_t state;
	slcd_pkg::lcd_byte_t  shreg;
	logic [2:0]           bit_cnt;
	logic                 phase;	// 0 = sclk low half, 1 = high half

	assign mosi = shreg[7];

	always_ff @(posedge lcdclk) begin
		if (rst) begin
			state     <= slcd_pkg::spi_idle;
			shreg     <= '0;
			bit_cnt   <= '0;
			phase     <= 1'b0;
			ss        <= 1'b1;
			sclk      <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			case (state)
				slcd_pkg::spi_idle: begin
					if (load) begin
						shreg   <= tx_byte;	// first bit on mosi as ss falls
						bit_cnt <= 3'd7;
						phase   <= 1'b0;
						ss      <= 1'b0;
						state   <= slcd_pkg::spi_shift;
					end
				end
				slcd_pkg::spi_shift: begin
					if (!phase) begin
						sclk  <= 1'b1;
						phase <= 1'b1;
					end else begin
						sclk  <= 1'b0;
						phase <= 1'b0;
						if (bit_cnt == 3'd0) begin
							state <= slcd_pkg::spi_last;
						end else begin
							bit_cnt <= bit_cnt - 1'b1;
							shreg   <= {shreg[6:0], 1'b0};	// next bit while sclk low
						end
					end
				end
				default: begin	// close the frame
					ss        <= 1'b1;
					byte_done <= 1'b1;
					shreg     <= '0;
					state     <= slcd_pkg::spi_idle;
				end
			endcase
		end
	end

	sclk_in_frame_a: assert property (@(posedge lcdclk) disable iff (rst)
		$changed(sclk) |-> !ss && !$past(ss));

endmodule

/* design/slcd_cmd_encoder.sv */
//********************
// command encoder: turns one command into its escape bytes
// hands them to the SPI transmitter one frame at a time
//********************

`timescale 1ns/10ps

module slcd_cmd_encoder (
	input  logic                lcdclk,
	input  logic                rst,
	input  logic                init,
	input  logic                req,
	input  slcd_pkg::lcd_cmd_t  cmd,
	output logic                ack,
	output logic                load,
	output slcd_pkg::lcd_byte_t tx_byte,
	input  logic                byte_done
);

	slcd_pkg::enc_state_t state;
	slcd_pkg::byte_idx_t  idx;
	slcd_pkg::byte_idx_t  last_idx;

	function automatic slcd_pkg::lcd_byte_t byte_at(slcd_pkg::lcd_cmd_t c,
			slcd_pkg::byte_idx_t i);
		case (c.op)
			slcd_pkg::op_enable: return slcd_pkg::esc_enable[8*(3-i) +: 8];
			slcd_pkg::op_home:   return slcd_pkg::esc_home[8*(5-i) +: 8];
			slcd_pkg::op_clear:  return slcd_pkg::esc_clear[8*(2-i) +: 8];
			default:             return c.ch;
		endcase
	endfunction

	always_comb begin
		case (cmd.op)
			slcd_pkg::op_enable: last_idx = 3'd3;
			slcd_pkg::op_home:   last_idx = 3'd5;
			slcd_pkg::op_clear:  last_idx = 3'd2;
			default:             last_idx = 3'd0;
		endcase
	end

	always_ff @(posedge lcdclk) begin
		if (rst) begin
			state <= slcd_pkg::enc_idle;
			idx   <= '0;
			load  <= 1'b0;
			ack   <= 1'b0;
		end else begin
			load <= 1'b0;
			ack  <= 1'b0;
			case (state)
				slcd_pkg::enc_idle: begin
					if (req) begin
						load    <= 1'b1;
						tx_byte <= byte_at(cmd, idx);
						state   <= slcd_pkg::enc_wait;
					end
				end
				slcd_pkg::enc_wait: begin
					if (!req) begin	// request withdrawn, let the frame finish
						state <= byte_done ? slcd_pkg::enc_idle : slcd_pkg::enc_drain;
					end else if (byte_done) begin
						if (idx == last_idx) begin
							ack   <= 1'b1;
							state <= slcd_pkg::enc_ack;
						end else begin
							idx     <= idx + 1'b1;
							load    <= 1'b1;
							tx_byte <= byte_at(cmd, idx + 1'b1);
						end
					end
				end
				slcd_pkg::enc_drain: if (byte_done) state <= slcd_pkg::enc_idle;
				default: state <= slcd_pkg::enc_idle;	// req drops next cycle
			endcase
			if (init)
				idx <= '0;
		end
	end

	// one byte in flight: no new load until the transmitter reports done
	one_frame_a: assert property (@(posedge lcdclk) disable iff (rst)
		load |=> !load until byte_done);

endmodule

/* design/slcd_msg_seq.sv */
//********************
// message sequencer: enable, home, clear, then each character
// one init pulse and one held request per command
//********************

`timescale 1ns/10ps

module slcd_msg_seq #(
	parameter logic [8*slcd_pkg::msg_max-1:0] msg_text = '0,
	parameter int msg_len = 1
) (
	input  logic                lcdclk,
	input  logic                rst,
	input  logic                btn_stable,
	output logic                init,
	output logic                req,
	output slcd_pkg::lcd_cmd_t  cmd,
	input  logic                ack,
	output logic                done
);

	slcd_pkg::seq_state_t state;
	slcd_pkg::cmd_idx_t   cmd_idx;

	// command for a sequence position; characters read left to right
	function automatic slcd_pkg::lcd_cmd_t cmd_at(slcd_pkg::cmd_idx_t i);
		slcd_pkg::lcd_cmd_t c;
		int ci;
		c.op = slcd_pkg::op_char;
		c.ch = '0;
		case (i)
			5'd0: c.op = slcd_pkg::op_enable;
			5'd1: c.op = slcd_pkg::op_home;
			5'd2: c.op = slcd_pkg::op_clear;
			default: begin
				ci   = int'(i) - 3;
				c.ch = msg_text[8*(slcd_pkg::msg_max-1-ci) +: 8];
			end
		endcase
		return c;
	endfunction

	always_ff @(posedge lcdclk) begin
		if (rst || btn_stable) begin	// button held, restart from the top
			state   <= slcd_pkg::seq_gap;
			cmd_idx <= '0;
			init    <= 1'b0;
			req     <= 1'b0;
			done    <= 1'b0;
		end else begin
			case (state)
				slcd_pkg::seq_gap: begin
					init  <= 1'b1;
					state <= slcd_pkg::seq_init;
				end
				slcd_pkg::seq_init: begin
					init  <= 1'b0;
					req   <= 1'b1;
					cmd   <= cmd_at(cmd_idx);
					state <= slcd_pkg::seq_req;
				end
				slcd_pkg::seq_req: begin
					if (ack) begin
						req <= 1'b0;
						if (cmd_idx == slcd_pkg::cmd_idx_t'(msg_len + 2)) begin
							done  <= 1'b1;	// last character taken
							state <= slcd_pkg::seq_done;
						end else begin
							cmd_idx <= cmd_idx + 1'b1;
							state   <= slcd_pkg::seq_gap;	// one idle cycle
						end
					end
				end
				default: state <= slcd_pkg::seq_done;	// hold until restart
			endcase
		end
	end

	// a request ends on an acknowledge or on a button restart
	req_fall_a: assert property (@(posedge lcdclk) disable iff (rst)
		$fell(req) |-> $past(ack) || $past(btn_stable));

	cmd_stable_a: assert property (@(posedge lcdclk) disable iff (rst)
		req && $past(req) |-> $stable(cmd));

endmodule

/* design/pb_debounce.sv */
//********************
// push-button synchronizer and debouncer
// btn_stable follows btn once it has settled
//********************

`timescale 1ns/10ps

module pb_debounce #(
	parameter int debounce_ticks = 8
) (
	input  logic lcdclk,
	input  logic rst,
	input  logic btn,
	output logic btn_stable
);

	logic [1:0] sync;	// two-stage synchronizer
	logic [$clog2(debounce_ticks+1)-1:0] cnt;

	always_ff @(posedge lcdclk) begin
		if (rst) begin
			sync       <= '0;
			cnt        <= '0;
			btn_stable <= 1'b0;
		end else begin
			sync <= {sync[0], btn};
			if (sync[1] != btn_stable) begin
				if (cnt == debounce_ticks - 1) begin
					btn_stable <= sync[1];	// settled long enough
					cnt        <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else begin
				cnt <= '0;	// bounce, start over
			end
		end
	end

endmodule

/* design/slcd_pkg.sv */
//********************
// shared types and escape codes for the serial LCD test path
// referenced by scoped name from the design modules
//********************

package slcd_pkg;

	localparam int msg_max = 16;	// longest message in characters

	typedef logic [7:0] lcd_byte_t;	// one byte on the SPI link
	typedef logic [2:0] byte_idx_t;	// byte position inside one command
	typedef logic [4:0] cmd_idx_t;	// command position inside the sequence

	typedef enum logic [1:0] {
		op_enable,
		op_home,
		op_clear,
		op_char
	} lcd_op_t;

	typedef struct packed {
		lcd_op_t   op;
		lcd_byte_t ch;	// only used by op_char
	} lcd_cmd_t;

	// escape sequences, first byte in the top bits
	localparam logic [31:0] esc_enable = {8'h1b, "[3e"};
	localparam logic [47:0] esc_home   = {8'h1b, "[0;0H"};
	localparam logic [23:0] esc_clear  = {8'h1b, "[j"};

	typedef enum logic [1:0] {
		seq_gap,
		seq_init,
		seq_req,
		seq_done
	} seq_state_t;

	typedef enum logic [1:0] {
		enc_idle,
		enc_wait,
		enc_drain,
		enc_ack
	} enc_state_t;

	typedef enum logic [1:0] {
		spi_idle,
		spi_shift,
		spi_last
	} spi_state_t;

endpackage
